// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= frontend_tb
FILELIST  ?= fetch.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== fetch.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/fetch_types_pkg.sv
logic/instr_scan.sv
logic/bht.sv
logic/ras.sv
logic/instr_queue.sv
logic/frontend.sv
test/frontend_checker.sv
test/frontend_tb.sv

// ==== logic/bht.sv ====
// branch history table of 2-bit saturating counters with update port
`include "fetch_defs.svh"

module bht
  import fetch_types_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [`VLEN-1:0] pc_i,
  input  logic             update_valid_i,
  input  logic [`VLEN-1:0] update_pc_i,
  input  logic             update_taken_i,
  output bht_prediction_t  prediction_o
);

  localparam int unsigned IDX_W = $clog2(`BHT_ENTRIES);

  logic [`BHT_ENTRIES-1:0] valid_q;
  logic [1:0]              cnt_q [`BHT_ENTRIES];
  logic [IDX_W-1:0]        rd_idx;
  logic [IDX_W-1:0]        wr_idx;

  // word index, the two low pc bits are always zero
  assign rd_idx = pc_i[IDX_W+1:2];
  assign wr_idx = update_pc_i[IDX_W+1:2];

  // combinational read, counter msb gives the direction
  assign prediction_o.valid = valid_q[rd_idx];
  assign prediction_o.taken = cnt_q[rd_idx][1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      for (int i = 0; i < `BHT_ENTRIES; i++) begin
        cnt_q[i] <= 2'b00;
      end
    end else if (update_valid_i) begin
      if (!valid_q[wr_idx]) begin
        // first outcome seen for this entry
        valid_q[wr_idx] <= 1'b1;
        cnt_q[wr_idx]   <= update_taken_i ? `BHT_WEAK_TAKEN : `BHT_WEAK_NOT_TAKEN;
      end else if (update_taken_i && cnt_q[wr_idx] != 2'b11) begin
        cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'd1;
      end else if (!update_taken_i && cnt_q[wr_idx] != 2'b00) begin
        cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'd1;
      end
    end
  end

endmodule

// ==== logic/fetch_defs.svh ====
// widths, depths and counter reset values of the fetch frontend
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address and data width
`define VLEN 32

// prediction structures
`define BHT_ENTRIES 16
`define RAS_DEPTH 2

// instruction queue toward decode
`define FETCH_QUEUE_DEPTH 4

// one 32-bit instruction per fetch
`define INSTR_BYTES 4

// counter value given to a history entry on its first update
`define BHT_WEAK_TAKEN 2'b10
`define BHT_WEAK_NOT_TAKEN 2'b01

`endif

// ==== logic/fetch_types_pkg.sv ====
// frontend types for control-flow class, history prediction and queue entry
`include "fetch_defs.svh"

package fetch_types_pkg;

  // class of a scanned instruction
  // a call links ra or t0, a return jumps through a link register without linking
  typedef enum logic [2:0] {
    CF_NONE   = 3'd0,
    CF_BRANCH = 3'd1,
    CF_JUMP   = 3'd2,
    CF_CALL   = 3'd3,
    CF_RETURN = 3'd4
  } cf_e;

  // read result of the branch history table
  typedef struct packed {
    logic valid;
    logic taken;
  } bht_prediction_t;

  // one instruction on its way to decode, 98 bits
  typedef struct packed {
    logic [`VLEN-1:0] pc;
    logic [31:0]      instr;
    logic             taken;
    // address fetched after this entry
    logic [`VLEN-1:0] target;
    logic             fault;
  } fetch_entry_t;

endpackage

// ==== logic/frontend.sv ====
// fetch frontend top with response register, prediction and next-pc select
`include "fetch_defs.svh"

module frontend
  import fetch_types_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [`VLEN-1:0] boot_addr_i,
  input  logic             flush_i,
  input  logic             halt_i,
  // resolved control flow from execute
  input  logic             resolve_valid_i,
  input  logic [`VLEN-1:0] resolve_pc_i,
  input  logic [`VLEN-1:0] resolve_target_i,
  input  logic             resolve_taken_i,
  input  logic             resolve_is_branch_i,
  input  logic             resolve_mispredict_i,
  // exception return, trap and commit redirects
  input  logic             eret_i,
  input  logic [`VLEN-1:0] epc_i,
  input  logic             ex_valid_i,
  input  logic [`VLEN-1:0] trap_vector_i,
  input  logic             set_pc_commit_i,
  input  logic [`VLEN-1:0] pc_commit_i,
  // instruction cache
  output logic             icache_req_o,
  output logic [`VLEN-1:0] icache_addr_o,
  output logic             icache_kill_o,
  input  logic             icache_ready_i,
  input  logic             icache_valid_i,
  input  logic [`VLEN-1:0] icache_vaddr_i,
  input  logic [31:0]      icache_data_i,
  input  logic             icache_fault_i,
  // decode
  output logic [`VLEN-1:0] fetch_pc_o,
  output logic [31:0]      fetch_instr_o,
  output logic             fetch_taken_o,
  output logic [`VLEN-1:0] fetch_target_o,
  output logic             fetch_fault_o,
  output logic             fetch_valid_o,
  input  logic             fetch_ready_i
);

  localparam logic [`VLEN-1:0] INSTR_INC = `INSTR_BYTES;

  // registered cache response
  logic             rsp_valid_q;
  logic [`VLEN-1:0] rsp_vaddr_q;
  logic [31:0]      rsp_data_q;
  logic             rsp_fault_q;
  logic [`VLEN-1:0] rsp_seq_pc;
  // high in the cycles before the boot address has been loaded
  logic             npc_rst_load_q;
  logic [`VLEN-1:0] npc_d;
  logic [`VLEN-1:0] npc_q;
  logic [`VLEN-1:0] fetch_address;
  logic             if_ready;
  // scan and predictor results
  cf_e              cf;
  logic [`VLEN-1:0] imm;
  bht_prediction_t  bht_pred;
  logic             ras_valid;
  logic [`VLEN-1:0] ras_top;
  logic             ras_push;
  logic             ras_pop;
  logic             bp_valid;
  logic [`VLEN-1:0] predict_address;
  // queue side
  logic             queue_valid;
  logic             queue_ready;
  logic             scan_valid;
  logic             accepted;
  logic             replay;
  logic [`VLEN-1:0] replay_addr;
  fetch_entry_t     queue_entry;
  fetch_entry_t     fetch_entry;
  // backend redirects
  logic             is_mispredict;
  logic             redirect;

  assign is_mispredict = resolve_valid_i & resolve_mispredict_i;
  assign redirect = flush_i | is_mispredict | eret_i | ex_valid_i | set_pc_commit_i;

  // ------------------------------------------------------------------------
  // control-flow prediction on the registered response
  // ------------------------------------------------------------------------
  instr_scan i_instr_scan (
    .instr_i (rsp_data_q),
    .cf_o    (cf),
    .imm_o   (imm)
  );

  bht i_bht (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pc_i           (rsp_vaddr_q),
    .update_valid_i (resolve_valid_i & resolve_is_branch_i),
    .update_pc_i    (resolve_pc_i),
    .update_taken_i (resolve_taken_i),
    .prediction_o   (bht_pred)
  );

  ras i_ras (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (ras_push),
    .pop_i   (ras_pop),
    .data_i  (rsp_seq_pc),
    .valid_o (ras_valid),
    .top_o   (ras_top)
  );

  assign rsp_seq_pc = rsp_vaddr_q + INSTR_INC;

  // a redirect drops the registered instruction
  assign queue_valid = rsp_valid_q & ~redirect;
  // faulting words carry no usable instruction
  assign scan_valid  = queue_valid & ~rsp_fault_q;
  // stack updates only for instructions that enter the queue
  assign accepted    = scan_valid & ~replay;

  always_comb begin
    bp_valid        = 1'b0;
    ras_push        = 1'b0;
    ras_pop         = 1'b0;
    predict_address = rsp_vaddr_q + imm;
    case (cf)
      CF_BRANCH: begin
        // dynamic direction if trained, else backward taken
        bp_valid = scan_valid & (bht_pred.valid ? bht_pred.taken : imm[`VLEN-1]);
      end
      CF_JUMP: bp_valid = scan_valid;
      CF_CALL: begin
        // opcode bit 3 set means jal, a jalr call has no known target
        bp_valid = scan_valid & rsp_data_q[3];
        ras_push = accepted;
      end
      CF_RETURN: begin
        predict_address = ras_top;
        bp_valid        = scan_valid & ras_valid;
        ras_pop         = accepted & ras_valid;
      end
      default: bp_valid = 1'b0;
    endcase
  end

  // ------------------------------------------------------------------------
  // cache request and kill
  // ------------------------------------------------------------------------
  // kill drops everything in flight, so no new request goes out with it
  assign icache_kill_o = redirect | replay | bp_valid;
  // nothing is requested while reset is held
  assign icache_req_o  = rst_ni & queue_ready & ~icache_kill_o;
  assign if_ready      = icache_req_o & icache_ready_i;
  assign icache_addr_o = fetch_address;

  // next pc, later assignments win
  always_comb begin
    fetch_address = npc_rst_load_q ? boot_addr_i : npc_q;
    npc_d         = fetch_address;
    if (bp_valid) begin
      fetch_address = predict_address;
      npc_d         = predict_address;
    end
    if (if_ready) begin
      npc_d = {fetch_address[`VLEN-1:2], 2'b00} + INSTR_INC;
    end
    if (replay) begin
      npc_d = replay_addr;
    end
    if (is_mispredict) begin
      npc_d = resolve_target_i;
    end
    if (eret_i) begin
      npc_d = epc_i;
    end
    if (ex_valid_i) begin
      npc_d = trap_vector_i;
    end
    // restart after the committing instruction, or at it when halted
    if (set_pc_commit_i) begin
      npc_d = pc_commit_i + (halt_i ? '0 : INSTR_INC);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      npc_rst_load_q <= 1'b1;
      npc_q          <= '0;
      rsp_valid_q    <= 1'b0;
    end else begin
      npc_rst_load_q <= 1'b0;
      npc_q          <= npc_d;
      // a response in a kill cycle belongs to a dropped request
      rsp_valid_q    <= icache_valid_i & ~icache_kill_o;
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (icache_valid_i) begin
      rsp_vaddr_q <= icache_vaddr_i;
      rsp_data_q  <= icache_data_i;
      rsp_fault_q <= icache_fault_i;
    end
  end

  // ------------------------------------------------------------------------
  // instruction queue toward decode
  // ------------------------------------------------------------------------
  assign queue_entry = '{
    pc:     rsp_vaddr_q,
    instr:  rsp_data_q,
    taken:  bp_valid,
    target: bp_valid ? predict_address : rsp_seq_pc,
    fault:  rsp_fault_q
  };

  instr_queue i_instr_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .valid_i       (queue_valid),
    .entry_i       (queue_entry),
    .ready_o       (queue_ready),
    .replay_o      (replay),
    .replay_addr_o (replay_addr),
    .fetch_entry_o (fetch_entry),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i)
  );

  assign fetch_pc_o     = fetch_entry.pc;
  assign fetch_instr_o  = fetch_entry.instr;
  assign fetch_taken_o  = fetch_entry.taken;
  assign fetch_target_o = fetch_entry.target;
  assign fetch_fault_o  = fetch_entry.fault;

endmodule

// ==== logic/instr_queue.sv ====
// fetch entry fifo toward decode with replay request on overflow
`include "fetch_defs.svh"

module instr_queue
  import fetch_types_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             valid_i,
  input  fetch_entry_t     entry_i,
  output logic             ready_o,
  output logic             replay_o,
  output logic [`VLEN-1:0] replay_addr_o,
  output fetch_entry_t     fetch_entry_o,
  output logic             fetch_valid_o,
  input  logic             fetch_ready_i
);

  localparam int unsigned PTR_W = $clog2(`FETCH_QUEUE_DEPTH);
  localparam int unsigned CNT_W = $clog2(`FETCH_QUEUE_DEPTH + 1);

  fetch_entry_t     mem_q [`FETCH_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count_q == CNT_W'(`FETCH_QUEUE_DEPTH));
  assign push = valid_i & ~full;
  assign pop  = fetch_valid_o & fetch_ready_i;

  // keep one slot spare for a response already on its way
  assign ready_o = (count_q <= CNT_W'(`FETCH_QUEUE_DEPTH - 2));

  // an entry that finds no room has to be fetched again
  assign replay_o      = valid_i & full;
  assign replay_addr_o = entry_i.pc;

  assign fetch_valid_o = (count_q != '0);
  assign fetch_entry_o = mem_q[rd_ptr_q];

  // ------------------------------------------------------------------------
  // pointers and fill level
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

// ==== logic/instr_scan.sv ====
// combinational control-flow scan of one instruction
`include "fetch_defs.svh"

module instr_scan
  import rv_isa_pkg::*;
  import fetch_types_pkg::*;
(
  input  logic [31:0]      instr_i,
  output cf_e              cf_o,
  output logic [`VLEN-1:0] imm_o
);

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       rd_link;
  logic       rs1_link;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // ra and t0 both count as link registers
  assign rd_link  = (rd == REG_RA) || (rd == REG_T0);
  assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);

  always_comb begin
    cf_o  = CF_NONE;
    // branch offset by default, its sign drives the static prediction
    imm_o = imm_b(instr_i);
    case (opcode)
      OPC_BRANCH: cf_o = CF_BRANCH;
      OPC_JAL: begin
        imm_o = imm_j(instr_i);
        cf_o  = rd_link ? CF_CALL : CF_JUMP;
      end
      OPC_JALR: begin
        // other register jumps have no known target and stay unpredicted
        if (rd_link) begin
          cf_o = CF_CALL;
        end else if (rs1_link) begin
          cf_o = CF_RETURN;
        end
      end
      default: cf_o = CF_NONE;
    endcase
  end

endmodule

// ==== logic/ras.sv ====
// return address stack with push and pop, entry 0 is the top
`include "fetch_defs.svh"

module ras (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [`VLEN-1:0] data_i,
  output logic             valid_o,
  output logic [`VLEN-1:0] top_o
);

  logic [`VLEN-1:0]      addr_q [`RAS_DEPTH];
  logic [`RAS_DEPTH-1:0] valid_q;

  assign valid_o = valid_q[0];
  assign top_o   = addr_q[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (push_i && pop_i) begin
      valid_q[0] <= 1'b1;
    end else if (push_i) begin
      // oldest entry drops off the bottom
      valid_q <= {valid_q[`RAS_DEPTH-2:0], 1'b1};
    end else if (pop_i) begin
      valid_q <= {1'b0, valid_q[`RAS_DEPTH-1:1]};
    end
  end

  // addresses follow the valid bits
  always_ff @(posedge clk_i) begin
    if (push_i && pop_i) begin
      addr_q[0] <= data_i;
    end else if (push_i) begin
      for (int i = `RAS_DEPTH - 1; i > 0; i--) begin
        addr_q[i] <= addr_q[i-1];
      end
      addr_q[0] <= data_i;
    end else if (pop_i) begin
      for (int i = 0; i < `RAS_DEPTH - 1; i++) begin
        addr_q[i] <= addr_q[i+1];
      end
    end
  end

endmodule

// ==== logic/rv_isa_pkg.sv ====
// risc-v opcodes, link register numbers and immediate extractors
`include "fetch_defs.svh"

package rv_isa_pkg;

  // control-flow opcodes of the base integer set
  typedef enum logic [6:0] {
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  // registers that act as link registers by convention
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_T0 = 5'd5;

  // sign-extended b-type immediate, bit 0 always clear
  function automatic logic [`VLEN-1:0] imm_b(input logic [31:0] instr);
    return {{(`VLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

  // sign-extended j-type immediate
  function automatic logic [`VLEN-1:0] imm_j(input logic [31:0] instr);
    return {{(`VLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

endpackage

// ==== test/frontend_checker.sv ====
// concurrent assertions on the frontend ports, bound into the frontend
`include "fetch_defs.svh"

module frontend_checker (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             flush_i,
  input logic             redirect_i,
  input logic             icache_req_i,
  input logic             icache_kill_i,
  input logic             fetch_valid_i,
  input logic             fetch_ready_i,
  input logic [`VLEN-1:0] fetch_pc_i,
  input logic [31:0]      fetch_instr_i,
  input logic             fetch_taken_i,
  input logic [`VLEN-1:0] fetch_target_i,
  input logic             fetch_fault_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // quiet outputs while reset is held
  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_ni |-> !fetch_valid_i && !icache_kill_i && !icache_req_i)
    else $error("fetch output active during reset");

  // stalled entry holds, a flush is the only way out
  entry_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && !fetch_ready_i && !flush_i |=>
      $stable(fetch_pc_i) && $stable(fetch_instr_i) && $stable(fetch_taken_i) &&
      $stable(fetch_target_i) && $stable(fetch_fault_i))
    else $error("fetch entry changed while stalled");

  // every redirect drops the requests in flight and its flush empties the queue
  redirect_kill_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    redirect_i |-> icache_kill_i ##1 !fetch_valid_i)
    else $error("redirect without cache kill or queue flush");

  // long stall, window covers responses still landing in the queue
  stall_no_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_valid_i && !fetch_ready_i)[*(4*`FETCH_QUEUE_DEPTH)] |-> !icache_req_i)
    else $error("cache request during long decode stall");

endmodule

bind frontend frontend_checker frontend_checker_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .flush_i        (flush_i),
  .redirect_i     (flush_i | eret_i | ex_valid_i | set_pc_commit_i |
                   (resolve_valid_i & resolve_mispredict_i)),
  .icache_req_i   (icache_req_o),
  .icache_kill_i  (icache_kill_o),
  .fetch_valid_i  (fetch_valid_o),
  .fetch_ready_i  (fetch_ready_i),
  .fetch_pc_i     (fetch_pc_o),
  .fetch_instr_i  (fetch_instr_o),
  .fetch_taken_i  (fetch_taken_o),
  .fetch_target_i (fetch_target_o),
  .fetch_fault_i  (fetch_fault_o)
);

// ==== test/frontend_tb.sv ====
// frontend testbench with cache model, reference predictor, stimulus and compare
`include "fetch_defs.svh"

module frontend_tb
  import rv_isa_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;
  localparam logic [31:0] EPC_ADDR  = 32'h0000_6100;
  localparam logic [31:0] TVEC_ADDR = 32'h0000_6200;
  localparam logic [31:0] CPC_ADDR  = 32'h0000_6300;
  localparam logic [31:0] NOP_WORD  = 32'h0000_0013;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic [31:0] boot_addr_i;
  logic flush_i, halt_i;
  logic resolve_valid_i, resolve_taken_i, resolve_is_branch_i, resolve_mispredict_i;
  logic [31:0] resolve_pc_i, resolve_target_i;
  logic eret_i, ex_valid_i, set_pc_commit_i;
  logic [31:0] epc_i, trap_vector_i, pc_commit_i;
  logic icache_req_o, icache_kill_o, icache_ready_i, icache_valid_i, icache_fault_i;
  logic [31:0] icache_addr_o, icache_vaddr_i, icache_data_i;
  logic [31:0] fetch_pc_o, fetch_instr_o, fetch_target_o;
  logic fetch_taken_o, fetch_fault_o, fetch_valid_o, fetch_ready_i;

  // program image, unlisted words are nops
  logic [31:0] prog_mem [logic [31:0]];
  // cache requests in flight with their answer cycle
  logic [31:0] pend_addr [$];
  int          pend_due [$];
  int          cyc = 0;
  int          xfer_count = 0;
  logic [31:0] exp_pc = BOOT_ADDR;
  // reference predictor state
  logic        bht_v [`BHT_ENTRIES];
  logic [1:0]  bht_c [`BHT_ENTRIES];
  logic        ras_v [`RAS_DEPTH];
  logic [31:0] ras_a [`RAS_DEPTH];

  frontend frontend_i (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] prog_word(input logic [31:0] addr);
    return prog_mem.exists(addr) ? prog_mem[addr] : NOP_WORD;
  endfunction

  function automatic logic is_fault(input logic [31:0] addr);
    return addr >= 32'h3000 && addr < 32'h4000;
  endfunction

  // beq x0, x0, off
  function automatic logic [31:0] enc_branch(input logic [12:0] off);
    return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'h000, rs1, 3'b000, rd, OPC_JALR};
  endfunction

  function automatic logic link_reg(input logic [4:0] r);
    return r == 5'd1 || r == 5'd5;
  endfunction

  // expected entry at pc, walks the stack like the frontend does
  function automatic void predict(input logic [31:0] pc, output logic [31:0] instr,
                                  output logic taken, output logic [31:0] target,
                                  output logic fault);
    logic [31:0] imm;
    logic [3:0]  idx;
    idx    = pc[5:2];
    instr  = prog_word(pc);
    fault  = is_fault(pc);
    taken  = 1'b0;
    target = pc + 32'd4;
    if (!fault && instr[6:0] == OPC_BRANCH) begin
      imm   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      // trained counter first, backward taken otherwise
      taken = bht_v[idx] ? bht_c[idx][1] : imm[31];
    end else if (!fault && instr[6:0] == OPC_JAL) begin
      imm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      taken = 1'b1;
    end
    if (taken) begin
      target = pc + imm;
    end
    if (!fault && (instr[6:0] == OPC_JAL || instr[6:0] == OPC_JALR) && link_reg(instr[11:7]))
    begin
      ras_a[1] = ras_a[0];
      ras_v[1] = ras_v[0];
      ras_a[0] = pc + 32'd4;
      ras_v[0] = 1'b1;
    end else if (!fault && instr[6:0] == OPC_JALR && link_reg(instr[19:15]) && ras_v[0])
    begin
      taken    = 1'b1;
      target   = ras_a[0];
      ras_a[0] = ras_a[1];
      ras_v[0] = ras_v[1];
      ras_v[1] = 1'b0;
    end
  endfunction

  // restart address, higher sources override lower ones
  function automatic logic [31:0] restart_pc(input logic [31:0] tgt, input logic er,
                                             input logic ex, input logic cm,
                                             input logic hl);
    logic [31:0] pc;
    pc = tgt;
    if (er) pc = EPC_ADDR;
    if (ex) pc = TVEC_ADDR;
    if (cm) pc = hl ? CPC_ADDR : CPC_ADDR + 32'd4;
    return pc;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------------------------------
  // cache model, in-order answers after 1 to 3 cycles
  // ------------------------------------------------------------------------
  always begin
    int due;
    @(negedge clk_i);
    cyc++;
    icache_valid_i = 1'b0;
    if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
      icache_valid_i = 1'b1;
      icache_vaddr_i = pend_addr.pop_front();
      void'(pend_due.pop_front());
      icache_data_i  = prog_word(icache_vaddr_i);
      icache_fault_i = is_fault(icache_vaddr_i);
    end
    // request side settles after the falling edge drive
    #1;
    if (icache_kill_o) begin
      pend_addr.delete();
      pend_due.delete();
    end else if (icache_req_o && icache_ready_i) begin
      due = cyc + 1 + int'($urandom % 3);
      if (pend_due.size() > 0 && due < pend_due[$]) due = pend_due[$];
      pend_addr.push_back(icache_addr_o);
      pend_due.push_back(due);
    end
  end

  // compare every transfer toward decode with the reference
  always begin
    logic [31:0] e_instr;
    logic [31:0] e_target;
    logic        e_taken;
    logic        e_fault;
    @(negedge clk_i);
    #1;
    if (rst_ni && fetch_valid_o && fetch_ready_i) begin
      predict(exp_pc, e_instr, e_taken, e_target, e_fault);
      check("fetch_pc_o", fetch_pc_o, exp_pc);
      check("fetch_instr_o", fetch_instr_o, e_instr);
      check("fetch_taken_o", 32'(fetch_taken_o), 32'(e_taken));
      check("fetch_target_o", fetch_target_o, e_target);
      check("fetch_fault_o", 32'(fetch_fault_o), 32'(e_fault));
      exp_pc = e_target;
      xfer_count++;
    end
  end

  // take n entries with decode ready pct percent of the time, ends on a falling edge
  task automatic consume(input int n, input int pct);
    int target;
    int waited;
    bit done;
    target = xfer_count + n;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      if (xfer_count >= target) begin
        fetch_ready_i = 1'b0;
        done = 1'b1;
      end else begin
        fetch_ready_i = ($urandom % 100) < pct;
        waited++;
        if (waited > 50 * n + 100) begin
          $display("timed out waiting for %0d fetch entries", n);
          $display("Regression failed");
          $fatal(1);
        end
      end
    end
  endtask

  // one redirect pulse with flush, called on a falling edge
  task automatic send_redirect(input logic mis, input logic br, input logic taken,
                               input logic [31:0] tgt, input logic er, input logic ex,
                               input logic cm, input logic hl);
    logic [3:0] idx;
    idx = 4'(32'h4004 >> 2);
    resolve_valid_i      = mis;
    resolve_mispredict_i = mis;
    resolve_is_branch_i  = br;
    resolve_taken_i      = taken;
    resolve_pc_i         = 32'h4004;
    resolve_target_i     = tgt;
    eret_i               = er;
    ex_valid_i           = ex;
    set_pc_commit_i      = cm;
    halt_i               = hl;
    flush_i              = 1'b1;
    fetch_ready_i        = 1'b0;
    exp_pc = restart_pc(tgt, er, ex, cm, hl);
    // 2-bit counter, first outcome lands on the weak state
    if (br && !bht_v[idx]) begin
      bht_v[idx] = 1'b1;
      bht_c[idx] = taken ? 2'b10 : 2'b01;
    end else if (br && taken && bht_c[idx] != 2'b11) begin
      bht_c[idx] = bht_c[idx] + 2'd1;
    end else if (br && !taken && bht_c[idx] != 2'b00) begin
      bht_c[idx] = bht_c[idx] - 2'd1;
    end
    @(negedge clk_i);
    {resolve_valid_i, resolve_mispredict_i, resolve_is_branch_i} = 3'b000;
    {eret_i, ex_valid_i, set_pc_commit_i, halt_i, flush_i} = 5'b00000;
  endtask

  initial begin
    void'($urandom(32'h20bd_7dd9));
    for (int i = 0; i < `BHT_ENTRIES; i++) bht_v[i] = 1'b0;
    for (int i = 0; i < `RAS_DEPTH; i++) ras_v[i] = 1'b0;
    rst_ni = 1'b0;
    boot_addr_i = BOOT_ADDR;
    {flush_i, halt_i, eret_i, ex_valid_i, set_pc_commit_i} = 5'b00000;
    {resolve_valid_i, resolve_taken_i, resolve_is_branch_i, resolve_mispredict_i} = 4'b0000;
    resolve_pc_i = '0;
    resolve_target_i = '0;
    epc_i = EPC_ADDR;
    trap_vector_i = TVEC_ADDR;
    pc_commit_i = CPC_ADDR;
    {icache_valid_i, icache_fault_i} = 2'b00;
    icache_ready_i = 1'b1;
    icache_vaddr_i = '0;
    icache_data_i = '0;
    fetch_ready_i = 1'b0;
    // branch loop, call and return pair, and a call loop
    prog_mem[32'h4004] = enc_branch(13'd8);
    prog_mem[32'h4008] = enc_jal(5'd0, 21'd8);
    prog_mem[32'h4010] = enc_branch(-13'sd12);
    prog_mem[32'h5000] = enc_jal(REG_RA, 21'h100);
    prog_mem[32'h5104] = enc_jalr(5'd0, REG_RA);
    prog_mem[32'h5004] = enc_jalr(5'd0, REG_RA);
    prog_mem[32'h7000] = enc_jal(REG_T0, 21'd16);
    prog_mem[32'h7010] = enc_jalr(5'd0, REG_RA);
    prog_mem[32'h7004] = enc_jal(5'd0, -21'sd4);
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    consume(4, 80);
    send_redirect(1'b1, 1'b0, 1'b0, 32'h2ff8, 1'b0, 1'b0, 1'b0, 1'b0);
    consume(4, 80);
    // static prediction
    send_redirect(1'b1, 1'b0, 1'b0, 32'h4000, 1'b0, 1'b0, 1'b0, 1'b0);
    consume(12, 80);
    // train the forward branch at 0x4004
    for (int i = 0; i < 5; i++) begin
      send_redirect(1'b1, 1'b1, i < 2, 32'h4000, 1'b0, 1'b0, 1'b0, 1'b0);
      consume(6, 80);
    end
    send_redirect(1'b1, 1'b0, 1'b0, 32'h5000, 1'b0, 1'b0, 1'b0, 1'b0);
    consume(6, 80);
    // redirect precedence
    send_redirect(1'b1, 1'b0, 1'b0, 32'h6000, 1'b0, 1'b0, 1'b0, 1'b0);
    consume(3, 80);
    send_redirect(1'b1, 1'b0, 1'b0, 32'h6000, 1'b1, 1'b0, 1'b0, 1'b0);
    consume(3, 80);
    send_redirect(1'b1, 1'b0, 1'b0, 32'h6000, 1'b1, 1'b1, 1'b0, 1'b0);
    consume(3, 80);
    send_redirect(1'b1, 1'b0, 1'b0, 32'h6000, 1'b1, 1'b1, 1'b1, 1'b0);
    consume(3, 80);
    send_redirect(1'b0, 1'b0, 1'b0, 32'h6000, 1'b0, 1'b0, 1'b1, 1'b1);
    consume(3, 80);
    // long stall fills the queue, then random back-pressure
    send_redirect(1'b1, 1'b0, 1'b0, 32'h7000, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (24) @(negedge clk_i);
    consume(300, 60);
    $display("Regression passed");
    $finish;
  end

endmodule
